// File: hdl/sd_pkg.sv
package sd_pkg;

    // SD clock half period in clk cycles.
    localparam logic [3:0] SD_CLK_DIV = 4'd4;

    localparam logic [5:0] CMD_FRAME_BITS = 6'd48;
    localparam logic [5:0] CMD_HEAD_BITS  = 6'd40;  // start, direction, index and argument.
    localparam logic [9:0] BLOCK_BYTES    = 10'd512;
    localparam logic [4:0] DATA_CRC_BITS  = 5'd16;

    // cpu register map.
    localparam logic [2:0] ADDR_ARG0       = 3'd0;
    localparam logic [2:0] ADDR_ARG1       = 3'd1;
    localparam logic [2:0] ADDR_ARG2       = 3'd2;
    localparam logic [2:0] ADDR_ARG3       = 3'd3;
    localparam logic [2:0] ADDR_CMD_STATUS = 3'd4;
    localparam logic [2:0] ADDR_DATA       = 3'd5;

    localparam int ST_RESP_READY = 0;
    localparam int ST_DATA_READY = 1;
    localparam int ST_CRC_ERR    = 2;
    localparam int ST_BUSY       = 3;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOAD,
        S_CRC,
        S_TX_CMD,
        S_RX_CMD,
        S_RX_DATA,
        S_RX_DCRC
    } sd_state_t;

endpackage

// File: hdl/sd_clk_gen.sv
`timescale 1ns/1ps

module sd_clk_gen (
    input  logic clk,
    input  logic rst,
    output logic o_sd_clk,
    output logic o_rise,
    output logic o_fall
);
    import sd_pkg::*;

    logic [3:0] div_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            div_cnt  <= '0;
            o_sd_clk <= 1'b0;
            o_rise   <= 1'b0;
            o_fall   <= 1'b0;
        end else if (div_cnt == SD_CLK_DIV - 4'd1) begin
            div_cnt  <= '0;
            o_sd_clk <= ~o_sd_clk;
            o_rise   <= ~o_sd_clk;  // strobes line up with the new level.
            o_fall   <= o_sd_clk;
        end else begin
            div_cnt <= div_cnt + 4'd1;
            o_rise  <= 1'b0;
            o_fall  <= 1'b0;
        end
    end

endmodule

// File: hdl/crc7.sv
`timescale 1ns/1ps

module crc7 (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             i_load,
    input  logic [sd_pkg::CMD_HEAD_BITS-1:0] i_data,
    output logic [6:0]                       o_crc,
    output logic                             o_valid
);
    import sd_pkg::*;

    logic [CMD_HEAD_BITS-1:0] head_sr;
    logic [5:0]               bits_left;
    logic                     fb;

    assign fb = head_sr[CMD_HEAD_BITS-1] ^ o_crc[6];

    always_ff @(posedge clk) begin
        if (rst) begin
            bits_left <= '0;
            o_valid   <= 1'b0;
        end else if (i_load) begin
            bits_left <= CMD_HEAD_BITS;
            o_valid   <= 1'b0;
        end else if (bits_left != 6'd0) begin
            bits_left <= bits_left - 6'd1;
            o_valid   <= (bits_left == 6'd1);  // rises with the last bit folded in.
        end
    end

    always_ff @(posedge clk) begin
        if (i_load) begin
            head_sr <= i_data;
            o_crc   <= '0;
        end else if (bits_left != 6'd0) begin
            head_sr <= {head_sr[CMD_HEAD_BITS-2:0], 1'b0};
            o_crc   <= {o_crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);  // x^7 + x^3 + 1.
        end
    end

endmodule

// File: hdl/crc16.sv
`timescale 1ns/1ps

module crc16 (
    input  logic        clk,
    input  logic        rst,
    input  logic        i_clear,
    input  logic        i_bit_en,
    input  logic        i_bit,
    output logic [15:0] o_crc
);

    logic fb;

    // msb first feedback as used on the SD data lines.
    assign fb = i_bit ^ o_crc[15];

    always_ff @(posedge clk) begin
        if (rst) begin
            o_crc <= '0;
        end else if (i_clear) begin
            o_crc <= '0;
        end else if (i_bit_en) begin
            o_crc <= {o_crc[14:0], 1'b0} ^ (fb ? 16'h1021 : 16'h0000);  // ccitt polynomial.
        end
    end

endmodule

// File: hdl/sd_controller.sv
`timescale 1ns/1ps

module sd_controller (
    input  logic       clk,
    input  logic       rst,
    input  logic       i_sd_clk_rise,
    input  logic       i_sd_clk_fall,
    input  logic       i_cs,
    input  logic       i_rw,
    input  logic [2:0] i_addr,
    input  logic [7:0] i_wdata,
    output logic [7:0] o_rdata,
    input  logic       i_sd_cmd,
    output logic       o_sd_cmd,
    input  logic       i_sd_data,
    output logic       o_sd_data
);
    import sd_pkg::*;

    logic [31:0]              arg;
    logic [5:0]               cmd_idx;
    logic [CMD_HEAD_BITS-1:0] head;
    logic [CMD_HEAD_BITS-1:0] tx_head;
    logic [47:0]              tx_frame;
    logic [38:0]              rx_shift;
    logic [31:0]              resp_payload;
    logic [7:0]               block_mem [BLOCK_BYTES];
    logic [6:0]               byte_sh;
    logic [8:0]               rd_ptr;
    logic [15:0]              rx_crc;
    logic [15:0]              rx_crc_next;
    logic [12:0]              bit_cnt;
    logic [7:0]               status;
    sd_state_t                state;

    logic resp_ready;
    logic data_ready;
    logic crc_err;
    logic busy;

    logic       crc7_load;
    logic [6:0] crc7_out;
    logic       crc7_valid;
    logic       crc16_clear;
    logic       crc16_en;
    logic [15:0] crc16_out;

    logic cmd_wr;
    logic status_rd;
    logic data_rd;
    logic start_rsp;
    logic start_dat;
    logic resp_last;

    assign cmd_wr    = i_cs & ~i_rw & (i_addr == ADDR_CMD_STATUS);
    assign status_rd = i_cs & i_rw & (i_addr == ADDR_CMD_STATUS);
    assign data_rd   = i_cs & i_rw & (i_addr == ADDR_DATA);

    // a command write in idle wins over a card start bit seen in the same cycle.
    assign start_rsp = (state == S_IDLE) & ~cmd_wr & i_sd_clk_rise & ~i_sd_cmd;
    assign start_dat = (state == S_IDLE) & ~cmd_wr & i_sd_clk_rise & i_sd_cmd & ~i_sd_data;
    assign resp_last = (state == S_RX_CMD) & i_sd_clk_rise
                     & (bit_cnt == {7'd0, CMD_FRAME_BITS - 6'd1});

    assign head        = {1'b0, 1'b1, cmd_idx, arg};
    assign tx_frame    = {tx_head, crc7_out, 1'b1};
    assign rx_crc_next = {rx_crc[14:0], i_sd_data};

    assign crc7_load   = (state == S_LOAD);
    assign crc16_clear = start_dat;
    assign crc16_en    = (state == S_RX_DATA) & i_sd_clk_rise;

    assign busy      = (state == S_LOAD) | (state == S_CRC) | (state == S_TX_CMD);
    assign o_sd_data = 1'b1;  // the host never writes blocks.

    always_comb begin
        status                = '0;
        status[ST_RESP_READY] = resp_ready;
        status[ST_DATA_READY] = data_ready;
        status[ST_CRC_ERR]    = crc_err;
        status[ST_BUSY]       = busy;
    end

    always_comb begin
        case (i_addr)
            ADDR_ARG0:       o_rdata = resp_payload[7:0];
            ADDR_ARG1:       o_rdata = resp_payload[15:8];
            ADDR_ARG2:       o_rdata = resp_payload[23:16];
            ADDR_ARG3:       o_rdata = resp_payload[31:24];
            ADDR_CMD_STATUS: o_rdata = status;
            ADDR_DATA:       o_rdata = block_mem[rd_ptr];
            default:         o_rdata = 8'h00;
        endcase
    end

    crc7 u_crc7 (
        .clk     (clk),
        .rst     (rst),
        .i_load  (crc7_load),
        .i_data  (head),
        .o_crc   (crc7_out),
        .o_valid (crc7_valid)
    );

    crc16 u_crc16 (
        .clk      (clk),
        .rst      (rst),
        .i_clear  (crc16_clear),
        .i_bit_en (crc16_en),
        .i_bit    (i_sd_data),
        .o_crc    (crc16_out)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= S_IDLE;
            bit_cnt    <= '0;
            o_sd_cmd   <= 1'b1;
            rd_ptr     <= '0;
            resp_ready <= 1'b0;
            data_ready <= 1'b0;
            crc_err    <= 1'b0;
        end else begin
            if (status_rd) begin
                resp_ready <= 1'b0;
            end
            if (data_rd) begin
                data_ready <= 1'b0;
                rd_ptr     <= rd_ptr + 9'd1;
            end

            case (state)
                S_IDLE: begin
                    bit_cnt <= '0;
                    if (cmd_wr) begin
                        state <= S_LOAD;
                    end else if (start_rsp) begin
                        state   <= S_RX_CMD;
                        bit_cnt <= 13'd1;  // the start bit is already in.
                    end else if (start_dat) begin
                        state  <= S_RX_DATA;
                        rd_ptr <= '0;
                    end
                end

                S_LOAD: begin
                    state <= S_CRC;
                end

                S_CRC: begin
                    if (bit_cnt == {7'd0, CMD_HEAD_BITS - 6'd1}) begin
                        state   <= S_TX_CMD;
                        bit_cnt <= '0;
                    end else begin
                        bit_cnt <= bit_cnt + 13'd1;
                    end
                end

                S_TX_CMD: begin
                    if (i_sd_clk_fall && crc7_valid) begin
                        if (bit_cnt == {7'd0, CMD_FRAME_BITS}) begin
                            o_sd_cmd <= 1'b1;  // end bit has had its full period.
                            state    <= S_IDLE;
                        end else begin
                            o_sd_cmd <= tx_frame[CMD_FRAME_BITS - 6'd1 - bit_cnt[5:0]];
                            bit_cnt  <= bit_cnt + 13'd1;
                        end
                    end
                end

                S_RX_CMD: begin
                    if (resp_last) begin
                        resp_ready <= 1'b1;
                        state      <= S_IDLE;
                    end else if (i_sd_clk_rise) begin
                        bit_cnt <= bit_cnt + 13'd1;
                    end
                end

                S_RX_DATA: begin
                    if (i_sd_clk_rise) begin
                        if (bit_cnt == {BLOCK_BYTES - 10'd1, 3'b111}) begin
                            state   <= S_RX_DCRC;
                            bit_cnt <= '0;
                        end else begin
                            bit_cnt <= bit_cnt + 13'd1;
                        end
                    end
                end

                S_RX_DCRC: begin
                    if (i_sd_clk_rise) begin
                        if (bit_cnt == {8'd0, DATA_CRC_BITS - 5'd1}) begin
                            data_ready <= 1'b1;
                            crc_err    <= (rx_crc_next != crc16_out);
                            state      <= S_IDLE;
                        end else begin
                            bit_cnt <= bit_cnt + 13'd1;
                        end
                    end
                end

                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (i_cs && !i_rw) begin
            case (i_addr)
                ADDR_ARG0: arg[7:0]   <= i_wdata;
                ADDR_ARG1: arg[15:8]  <= i_wdata;
                ADDR_ARG2: arg[23:16] <= i_wdata;
                ADDR_ARG3: arg[31:24] <= i_wdata;
                default: ;
            endcase
        end
        if (cmd_wr && state == S_IDLE) begin
            cmd_idx <= i_wdata[5:0];
        end
        if (crc7_load) begin
            tx_head <= head;  // later argument writes cannot disturb the frame.
        end
        if (start_rsp || (state == S_RX_CMD && i_sd_clk_rise)) begin
            rx_shift <= {rx_shift[37:0], i_sd_cmd};
        end
        if (resp_last) begin
            resp_payload <= rx_shift[38:7];  // frame bits 39 down to 8.
        end
        if (crc16_en) begin
            byte_sh <= {byte_sh[5:0], i_sd_data};
        end
        if (state == S_RX_DCRC && i_sd_clk_rise) begin
            rx_crc <= rx_crc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (crc16_en && bit_cnt[2:0] == 3'b111) begin
            block_mem[bit_cnt[11:3]] <= {byte_sh, i_sd_data};
        end
    end

endmodule

// File: hdl/sd_host_top.sv
`timescale 1ns/1ps

module sd_host_top (
    input  logic       clk,
    input  logic       rst,
    input  logic       i_cs,
    input  logic       i_rw,
    input  logic [2:0] i_addr,
    input  logic [7:0] i_wdata,
    output logic [7:0] o_rdata,
    input  logic       i_sd_cmd,
    output logic       o_sd_cmd,
    input  logic       i_sd_data,
    output logic       o_sd_data,
    output logic       o_sd_clk
);

    logic sd_rise;
    logic sd_fall;

    sd_clk_gen u_clk_gen (
        .clk      (clk),
        .rst      (rst),
        .o_sd_clk (o_sd_clk),
        .o_rise   (sd_rise),
        .o_fall   (sd_fall)
    );

    sd_controller u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .i_sd_clk_rise (sd_rise),
        .i_sd_clk_fall (sd_fall),
        .i_cs          (i_cs),
        .i_rw          (i_rw),
        .i_addr        (i_addr),
        .i_wdata       (i_wdata),
        .o_rdata       (o_rdata),
        .i_sd_cmd      (i_sd_cmd),
        .o_sd_cmd      (o_sd_cmd),
        .i_sd_data     (i_sd_data),
        .o_sd_data     (o_sd_data)
    );

endmodule

// File: tests/sd_host_sva.sv
`timescale 1ns/1ps

module sd_host_sva (
    input logic              clk,
    input logic              rst,
    input sd_pkg::sd_state_t i_state,
    input logic [12:0]       i_bit_cnt,
    input logic              i_sd_clk_fall,
    input logic              i_crc7_valid,
    input logic              i_busy,
    input logic              i_resp_ready,
    input logic              i_status_rd,
    input logic              i_sd_cmd_out,
    input logic              i_sd_data_out
);
    import sd_pkg::*;

    int unsigned sva_errors = 0;
    logic        tx_step;

    assign tx_step = (i_state == S_TX_CMD) && i_sd_clk_fall && i_crc7_valid;  // one frame bit out.

    idle_lines_high: assert property (@(posedge clk) disable iff (rst)
        (i_state == S_IDLE) |-> (i_sd_cmd_out && i_sd_data_out))
    else begin
        sva_errors++;
        $error("cmd or data line low while the controller is idle");
    end

    // the end bit holds for one full SD clock period before busy drops.
    busy_clears: assert property (@(posedge clk) disable iff (rst)
        (tx_step && i_bit_cnt == 13'd47)
        |=> (i_busy && i_sd_cmd_out) [*2 * SD_CLK_DIV] ##1 (!i_busy && i_sd_cmd_out))
    else begin
        sva_errors++;
        $error("busy did not clear one SD clock period after the end bit went out");
    end

    resp_ready_clears: assert property (@(posedge clk) disable iff (rst)
        (i_status_rd && i_state != S_RX_CMD) |=> !i_resp_ready)
    else begin
        sva_errors++;
        $error("response ready still set after a status read");
    end

endmodule

bind sd_controller sd_host_sva u_sva (
    .clk           (clk),
    .rst           (rst),
    .i_state       (state),
    .i_bit_cnt     (bit_cnt),
    .i_sd_clk_fall (i_sd_clk_fall),
    .i_crc7_valid  (crc7_valid),
    .i_busy        (busy),
    .i_resp_ready  (resp_ready),
    .i_status_rd   (status_rd),
    .i_sd_cmd_out  (o_sd_cmd),
    .i_sd_data_out (o_sd_data)
);

// File: tests/sd_host_tb.sv
`timescale 1ns/1ps

module sd_host_tb;
    import sd_pkg::*;

    localparam int CLK_HALF_NS    = 4;
    localparam int SD_PERIOD_NS   = 2 * SD_CLK_DIV * 2 * CLK_HALF_NS;
    localparam int ALL_FRAME_BITS = 3 * CMD_FRAME_BITS + 2 * (BLOCK_BYTES * 8 + DATA_CRC_BITS + 2);
    localparam int WATCHDOG_NS    = 2 * ALL_FRAME_BITS * SD_PERIOD_NS;

    logic       clk;
    logic       rst;
    logic       cs;
    logic       rw;
    logic [2:0] addr;
    logic [7:0] wdata;
    logic [7:0] rdata;
    logic       card_cmd;
    logic       host_cmd;
    logic       card_data;
    logic       host_data;
    logic       sd_clk;

    logic [31:0] rng_state;
    logic [7:0]  block_bytes [512];
    int          test_errors;
    int          total_errors;
    int          tests_run;
    int          tests_failed;
    int          sva_seen;

    sd_host_top uut (
        .clk       (clk),
        .rst       (rst),
        .i_cs      (cs),
        .i_rw      (rw),
        .i_addr    (addr),
        .i_wdata   (wdata),
        .o_rdata   (rdata),
        .i_sd_cmd  (card_cmd),
        .o_sd_cmd  (host_cmd),
        .i_sd_data (card_data),
        .o_sd_data (host_data),
        .o_sd_clk  (sd_clk)
    );

    always #CLK_HALF_NS clk = ~clk;

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // remainder of head * x^7 divided by x^7 + x^3 + 1.
    function automatic logic [6:0] calc_crc7(input logic [39:0] head);
        logic [46:0] rem;
        rem = {head, 7'd0};
        for (int i = 46; i >= 7; i--) begin
            if (rem[i]) begin
                rem[i -: 8] = rem[i -: 8] ^ 8'h89;
            end
        end
        return rem[6:0];
    endfunction

    function automatic logic [15:0] calc_crc16();
        logic [15:0] crc;
        crc = '0;
        for (int n = 0; n < 512; n++) begin
            crc = crc ^ {block_bytes[n], 8'h00};
            for (int k = 0; k < 8; k++) begin
                crc = crc[15] ? ({crc[14:0], 1'b0} ^ 16'h1021) : {crc[14:0], 1'b0};
            end
        end
        return crc;
    endfunction

    function automatic logic [47:0] build_frame(input logic dir, input logic [5:0] idx,
                                                input logic [31:0] arg);
        logic [39:0] head;
        head = {1'b0, dir, idx, arg};
        return {head, calc_crc7(head), 1'b1};
    endfunction

    task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
        assert (act === exp) else begin
            $display("MISMATCH %s expected %0h actual %0h", name, exp, act);
            test_errors++;
        end
    endtask

    task automatic finish_test(input string name);
        int sva_now;
        sva_now = uut.u_ctrl.u_sva.sva_errors;
        if (sva_now != sva_seen) begin
            $display("%0d assertion failures during test %s", sva_now - sva_seen, name);
            test_errors += sva_now - sva_seen;
            sva_seen = sva_now;
        end
        tests_run++;
        if (test_errors == 0) begin
            $display("PASS %s", name);
        end else begin
            tests_failed++;
            $display("FAIL %s with %0d errors", name, test_errors);
        end
        total_errors += test_errors;
        test_errors = 0;
    endtask

    task automatic cpu_write(input logic [2:0] a, input logic [7:0] d);
        @(posedge clk);
        cs    <= 1'b1;
        rw    <= 1'b0;
        addr  <= a;
        wdata <= d;
        @(posedge clk);
        cs <= 1'b0;
    endtask

    task automatic cpu_read(input logic [2:0] a, output logic [7:0] d);
        @(posedge clk);
        cs   <= 1'b1;
        rw   <= 1'b1;
        addr <= a;
        @(negedge clk);
        d = rdata;  // rdata is combinational from the address.
        @(posedge clk);
        cs <= 1'b0;
    endtask

    task automatic poll_status(input int bit_idx, output logic [7:0] st);
        int reads;
        reads = 0;
        do begin
            cpu_read(ADDR_CMD_STATUS, st);
            reads++;
        end while (!st[bit_idx] && reads < 64);
        if (!st[bit_idx]) begin
            $display("status bit %0d never got set", bit_idx);
            test_errors++;
        end
    endtask

    task automatic write_command(input logic [31:0] arg, input logic [5:0] idx);
        for (int b = 0; b < 4; b++) begin
            cpu_write(3'(b), arg[8*b +: 8]);
        end
        cpu_write(ADDR_CMD_STATUS, {2'b00, idx});
    endtask

    task automatic drive_cmd_bit(input logic b);
        @(negedge sd_clk);
        @(posedge clk);
        card_cmd <= b;
    endtask

    task automatic drive_data_bit(input logic b);
        @(negedge sd_clk);
        @(posedge clk);
        card_data <= b;
    endtask

    task automatic capture_cmd_frame(output logic [47:0] frame);
        do begin
            @(posedge sd_clk);
        end while (host_cmd !== 1'b0);
        frame = 48'd0;  // the start bit is already in.
        repeat (47) begin
            @(posedge sd_clk);
            frame = {frame[46:0], host_cmd};
        end
    endtask

    task automatic send_response(input logic [47:0] frame);
        for (int i = 47; i >= 0; i--) begin
            drive_cmd_bit(frame[i]);
        end
    endtask

    task automatic fill_block();
        logic [31:0] rnd;
        for (int n = 0; n < 512; n++) begin
            rnd = next_rand();
            block_bytes[n] = rnd[23:16];
        end
    endtask

    task automatic send_block(input logic flip_crc);
        logic [15:0] crc;
        crc = calc_crc16() ^ (flip_crc ? 16'h0100 : 16'h0000);
        drive_data_bit(1'b0);
        for (int n = 0; n < 512; n++) begin
            for (int k = 7; k >= 0; k--) begin
                drive_data_bit(block_bytes[n][k]);
            end
        end
        for (int k = 15; k >= 0; k--) begin
            drive_data_bit(crc[k]);
        end
        drive_data_bit(1'b1);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, a transfer never completed", WATCHDOG_NS);
        $display("Test failures found");
        $finish;
    end

    initial begin
        logic [47:0] frame;
        logic [31:0] arg;
        logic [31:0] payload;
        logic [31:0] rnd;
        logic [5:0]  idx;
        logic [7:0]  st;
        logic [7:0]  rd;
        int          extra_starts;

        clk          = 1'b0;
        rst          = 1'b1;
        cs           = 1'b0;
        rw           = 1'b1;
        addr         = '0;
        wdata        = '0;
        card_cmd     = 1'b1;
        card_data    = 1'b1;
        rng_state    = 32'd21;
        test_errors  = 0;
        total_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        sva_seen     = 0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        repeat (4) @(posedge clk);
        cpu_read(ADDR_CMD_STATUS, st);
        @(negedge clk);
        check_value("reset status", 8'h00, st);
        check_value("reset cmd line", 1, host_cmd);
        check_value("reset data line", 1, host_data);
        finish_test("reset");

        arg = next_rand();
        rnd = next_rand();
        idx = rnd[31:26];
        fork
            capture_cmd_frame(frame);
            write_command(arg, idx);
        join
        check_value("command frame", build_frame(1'b1, idx, arg), frame);
        @(negedge sd_clk);  // the end bit finishes at this fall.
        cpu_read(ADDR_CMD_STATUS, st);
        check_value("busy after frame", 0, st[ST_BUSY]);
        finish_test("command frame");

        rnd     = next_rand();
        payload = next_rand();
        idx     = rnd[31:26];
        send_response(build_frame(1'b0, idx, payload));
        poll_status(ST_RESP_READY, st);
        check_value("response status", 8'h01, st);
        for (int b = 0; b < 4; b++) begin
            cpu_read(3'(b), rd);
            check_value("response payload", payload[8*b +: 8], rd);
        end
        cpu_read(ADDR_CMD_STATUS, st);
        check_value("response ready cleared", 8'h00, st);
        finish_test("response receive");

        fill_block();
        send_block(1'b0);
        poll_status(ST_DATA_READY, st);
        check_value("block status", 8'h02, st);
        for (int n = 0; n < 512; n++) begin
            cpu_read(ADDR_DATA, rd);
            check_value("block data", block_bytes[n], rd);
        end
        finish_test("data block");

        fill_block();
        send_block(1'b1);
        poll_status(ST_DATA_READY, st);
        check_value("crc error status", 8'h06, st);
        finish_test("crc error");

        arg = next_rand();
        rnd = next_rand();
        idx = rnd[31:26];
        fork
            capture_cmd_frame(frame);
            begin
                write_command(arg, idx);
                cpu_write(ADDR_CMD_STATUS, {2'b00, idx ^ 6'h2a});  // lands while busy.
            end
        join
        check_value("frame after ignored write", build_frame(1'b1, idx, arg), frame);
        @(negedge sd_clk);
        cpu_read(ADDR_CMD_STATUS, st);
        check_value("busy after ignored write", 0, st[ST_BUSY]);
        extra_starts = 0;
        repeat (10) begin
            @(posedge sd_clk);
            if (host_cmd !== 1'b1) begin
                extra_starts++;
            end
        end
        check_value("single frame", 0, extra_starts);
        finish_test("busy ignore");

        $display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
                 tests_run, tests_run - tests_failed, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: sd_host.f
hdl/sd_pkg.sv
hdl/sd_clk_gen.sv
hdl/crc7.sv
hdl/crc16.sv
hdl/sd_controller.sv
hdl/sd_host_top.sv
tests/sd_host_sva.sv
tests/sd_host_tb.sv
